//--- vrf_sys.f
logic/vrf_geom_pkg.sv
logic/vfu_pkg.sv
logic/vec_bank.sv
logic/vec_regfile.sv
logic/vec_alu.sv
logic/vec_lsu.sv
logic/vrf_sys_top.sv
test/vec_regfile_properties.sv
test/vrf_sys_tb.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module vrf_sys_tb -Mdir obj_dir -o vrf_sys_sim -f vrf_sys.f

run: compile
	./obj_dir/vrf_sys_sim > sim.log 2>&1; status=$$?; cat sim.log; test $$status -eq 0
	! grep -q "TESTS FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/vrf_sys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_sys_tb;

  import vrf_geom_pkg::*;
  import vfu_pkg::*;

  localparam int unsigned NrWords = NrVregs * WordsPerVreg;
  // Roughly 700 cycles of traffic in all tests, limit leaves a wide margin
  localparam int MaxCycles = 2000;

  logic     clk;
  logic     rst_n;
  logic     alu_start;
  alu_op_e  alu_op;
  row_t     alu_vd;
  row_t     alu_vs1;
  row_t     alu_vs2;
  logic     alu_busy;
  logic     alu_done;
  logic     load_req;
  addr_t    load_addr;
  data_t    load_data;
  be_t      load_be;
  logic     store_req;
  addr_t    store_addr;
  logic     load_done;
  logic     store_valid;
  data_t    store_data;

  // Reference model and bookkeeping
  data_t       model_mem [NrWords] = '{default: '0};
  data_t       alu_result [WordsPerVreg];
  row_t        alu_dest;
  int          alu_start_cnt;
  int          accept_cnt = 0;
  int          alu_done_cnt = 0;
  addr_t       ld_addr;
  data_t       ld_data;
  be_t         ld_be;
  int          ld_req_cnt;
  addr_t       st_addr;
  int          st_req_cnt;
  logic        check_idle;
  int          cycle_cnt = 0;
  int          check_cnt = 0;
  int          error_cnt = 0;
  logic [31:0] lfsr_state;

  vrf_sys_top #(
    .NrRows (NrVregs)
  ) dut_i (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .alu_start_i   (alu_start),
    .alu_op_i      (alu_op),
    .alu_vd_i      (alu_vd),
    .alu_vs1_i     (alu_vs1),
    .alu_vs2_i     (alu_vs2),
    .alu_busy_o    (alu_busy),
    .alu_done_o    (alu_done),
    .load_req_i    (load_req),
    .load_addr_i   (load_addr),
    .load_data_i   (load_data),
    .load_be_i     (load_be),
    .store_req_i   (store_req),
    .store_addr_i  (store_addr),
    .load_done_o   (load_done),
    .store_valid_o (store_valid),
    .store_data_o  (store_data)
  );

  bind vec_regfile vec_regfile_properties i_vec_regfile_properties (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .waddr_i  (waddr_i),
    .we_i     (we_i),
    .wvalid_i (wvalid_o),
    .raddr_i  (raddr_i),
    .re_i     (re_i),
    .rvalid_i (rvalid_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt >= MaxCycles);
    $display("Timeout: run went past %0d cycles without finishing", MaxCycles);
    $display("TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Model helpers
  ////////////////////////////////////////////////////////////////////////////

  // Right-shifting Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input be_t be);
    data_t w;
    w = old_word;
    for (int b = 0; b < WordWidth / 8; b++) begin
      if (be[b]) w[8*b +: 8] = new_word[8*b +: 8];
    end
    return w;
  endfunction

  // a is the vs2 element, b the vs1 element
  function automatic data_t alu_ref(input alu_op_e op, input data_t a, input data_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      default: return a ^ b;
    endcase
  endfunction

  function automatic addr_t elem_addr(input row_t r, input int e);
    return {r, BankBits'(e)};
  endfunction

  task automatic draw_bits(input int n, output data_t value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value[i]   = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic expect_equal(input string name, input data_t got, input data_t exp);
    check_cnt++;
    assert (got === exp) else begin
      error_cnt++;
      $display("Error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    check_cnt++;
    assert (cond) else begin
      error_cnt++;
      $display("%s", what);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor, sampled at the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      if (check_idle) begin
        expect_equal("alu_busy_o", 32'(alu_busy), 32'h0);
        expect_equal("alu_done_o", 32'(alu_done), 32'h0);
        expect_equal("load_done_o", 32'(load_done), 32'h0);
        expect_equal("store_valid_o", 32'(store_valid), 32'h0);
      end
      // Busy spans cycles 1 to 5 after the last accepted start
      if (accept_cnt > 0) begin
        expect_equal("alu_busy_o", 32'(alu_busy),
                     32'((cycle_cnt - alu_start_cnt >= 1) && (cycle_cnt - alu_start_cnt <= 5)));
      end
      if (store_valid) begin
        expect_equal($sformatf("store_data_o from %h", st_addr), store_data,
                     model_mem[st_addr]);
        expect_true(cycle_cnt - st_req_cnt >= 2,
                    $sformatf("Store from %h finished in under 2 cycles", st_addr));
      end
      if (load_done) begin
        expect_true(cycle_cnt - ld_req_cnt >= 2,
                    $sformatf("Load to %h finished in under 2 cycles", ld_addr));
        model_mem[ld_addr] = merge_bytes(model_mem[ld_addr], ld_data, ld_be);
      end
      if (alu_done) begin
        expect_true(accept_cnt > alu_done_cnt, "ALU signalled done with no command accepted");
        expect_true(cycle_cnt - alu_start_cnt == 5,
                    $sformatf("ALU done came %0d cycles after start instead of 5",
                              cycle_cnt - alu_start_cnt));
        for (int e = 0; e < WordsPerVreg; e++) begin
          model_mem[elem_addr(alu_dest, e)] = alu_result[e];
        end
        alu_done_cnt++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic step_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic load_word(input addr_t addr, input data_t data, input be_t be);
    step_cycle();
    ld_addr    = addr;
    ld_data    = data;
    ld_be      = be;
    ld_req_cnt = cycle_cnt;
    load_req   = 1'b1;
    load_addr  = addr;
    load_data  = data;
    load_be    = be;
    step_cycle();
    load_req = 1'b0;
    do @(negedge clk); while (!load_done);
  endtask

  task automatic store_word(input addr_t addr);
    step_cycle();
    st_addr    = addr;
    st_req_cnt = cycle_cnt;
    store_req  = 1'b1;
    store_addr = addr;
    step_cycle();
    store_req = 1'b0;
    do @(negedge clk); while (!store_valid);
  endtask

  task automatic fill_vreg(input row_t r);
    data_t word;
    for (int e = 0; e < WordsPerVreg; e++) begin
      draw_bits(WordWidth, word);
      load_word(elem_addr(r, e), word, '1);
    end
  endtask

  task automatic dump_vreg(input row_t r);
    for (int e = 0; e < WordsPerVreg; e++) begin
      store_word(elem_addr(r, e));
    end
  endtask

  // Holds start for hold cycles and returns once done was seen
  task automatic alu_run(input alu_op_e op, input row_t vd, input row_t vs1,
                         input row_t vs2, input int hold);
    int   held;
    logic seen;
    step_cycle();
    for (int e = 0; e < WordsPerVreg; e++) begin
      alu_result[e] = alu_ref(op, model_mem[elem_addr(vs2, e)], model_mem[elem_addr(vs1, e)]);
    end
    alu_dest      = vd;
    alu_start_cnt = cycle_cnt;
    accept_cnt++;
    alu_start = 1'b1;
    alu_op    = op;
    alu_vd    = vd;
    alu_vs1   = vs1;
    alu_vs2   = vs2;
    held = 0;
    seen = 1'b0;
    while (!seen || held < hold) begin
      @(negedge clk);
      if (alu_done) seen = 1'b1;
      step_cycle();
      held++;
      if (held >= hold) alu_start = 1'b0;
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    $display("test %0d, %s: %0d errors", num, name, error_cnt - errs_before);
  endtask

  initial begin
    int    errs;
    data_t word;
    data_t bits;
    rst_n      = 1'b0;
    alu_start  = 1'b0;
    alu_op     = OP_ADD;
    alu_vd     = '0;
    alu_vs1    = '0;
    alu_vs2    = '0;
    load_req   = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    load_be    = '0;
    store_req  = 1'b0;
    store_addr = '0;
    check_idle = 1'b0;
    lfsr_state = 32'hded4;

    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    errs = error_cnt;
    check_idle = 1'b1;
    step_cycle();
    check_idle = 1'b0;
    for (int a = 0; a < NrWords; a++) store_word(addr_t'(a));
    report_test(1, "reset state", errs);

    errs = error_cnt;
    for (int a = 0; a < NrWords; a++) begin
      draw_bits(WordWidth, word);
      draw_bits(WordWidth / 8, bits);
      load_word(addr_t'(a), word, be_t'(bits));
      store_word(addr_t'(a));
    end
    report_test(2, "byte-enabled loads", errs);

    errs = error_cnt;
    for (int o = 0; o < 4; o++) begin
      fill_vreg(row_t'(0));
      fill_vreg(row_t'(1));
      alu_run(alu_op_e'(2'(o)), row_t'(4), row_t'(0), row_t'(1), 1);
      dump_vreg(row_t'(4));
    end
    report_test(3, "ALU opcodes", errs);

    // LSU traffic on the same banks while the ALU streams
    errs = error_cnt;
    fill_vreg(row_t'(0));
    fill_vreg(row_t'(1));
    fork
      alu_run(OP_ADD, row_t'(4), row_t'(0), row_t'(1), 1);
      begin
        // First load waits on bank 0 while the ALU writes element 0 there
        @(posedge clk);
        fill_vreg(row_t'(5));
      end
      dump_vreg(row_t'(6));
    join
    dump_vreg(row_t'(4));
    dump_vreg(row_t'(5));
    report_test(4, "LSU under ALU load", errs);

    // vd equals vs1, so a second run would change the register
    errs = error_cnt;
    fill_vreg(row_t'(2));
    fill_vreg(row_t'(3));
    alu_run(OP_ADD, row_t'(2), row_t'(2), row_t'(3), 6);
    repeat (8) @(negedge clk);
    dump_vreg(row_t'(2));
    report_test(5, "start while busy", errs);

    $display("%0d checks, %0d errors", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : vrf_sys_tb

`default_nettype wire

//--- test/vec_regfile_properties.sv
`timescale 1ns/1ps
`default_nettype none

module vec_regfile_properties (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  input  vrf_geom_pkg::addr_t [vrf_geom_pkg::NrWritePorts-1:0] waddr_i,
  input  logic                [vrf_geom_pkg::NrWritePorts-1:0] we_i,
  input  logic                [vrf_geom_pkg::NrWritePorts-1:0] wvalid_i,
  input  vrf_geom_pkg::addr_t [vrf_geom_pkg::NrReadPorts-1:0]  raddr_i,
  input  logic                [vrf_geom_pkg::NrReadPorts-1:0]  re_i,
  input  logic                [vrf_geom_pkg::NrReadPorts-1:0]  rvalid_i
);

  import vrf_geom_pkg::*;

  logic alu_wr_same_bank;
  logic vs1_rd_same_bank;

  // ALU traffic that competes with the LSU for one bank port
  assign alu_wr_same_bank = we_i[ALU_WR] &&
      (waddr_i[ALU_WR][BankBits-1:0] == waddr_i[LSU_WR][BankBits-1:0]);
  assign vs1_rd_same_bank = re_i[ALU_VS1_RD] &&
      (raddr_i[ALU_VS1_RD][BankBits-1:0] == raddr_i[LSU_RD][BankBits-1:0]);

  lsu_write_yields: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wvalid_i[LSU_WR] |-> !alu_wr_same_bank)
    else $error("LSU write granted while the ALU writes the same bank");

  lsu_read_yields: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rvalid_i[LSU_RD] |-> !vs1_rd_same_bank)
    else $error("LSU read granted while vs1 reads the same bank");

  write_grant_needs_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (wvalid_i & ~we_i) == '0)
    else $error("Write grant without a write request");

  read_grant_needs_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (rvalid_i & ~re_i) == '0)
    else $error("Read grant without a read request");

endmodule : vec_regfile_properties

`default_nettype wire

//--- logic/vrf_sys_top.sv
`timescale 1ns/1ps
`default_nettype none

module vrf_sys_top #(
  parameter int unsigned NrRows = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // ALU command
  input  logic                  alu_start_i,
  input  vfu_pkg::alu_op_e      alu_op_i,
  input  vrf_geom_pkg::row_t    alu_vd_i,
  input  vrf_geom_pkg::row_t    alu_vs1_i,
  input  vrf_geom_pkg::row_t    alu_vs2_i,
  output logic                  alu_busy_o,
  output logic                  alu_done_o,
  // LSU requests
  input  logic                  load_req_i,
  input  vrf_geom_pkg::addr_t   load_addr_i,
  input  vrf_geom_pkg::data_t   load_data_i,
  input  vrf_geom_pkg::be_t     load_be_i,
  input  logic                  store_req_i,
  input  vrf_geom_pkg::addr_t   store_addr_i,
  output logic                  load_done_o,
  output logic                  store_valid_o,
  output vrf_geom_pkg::data_t   store_data_o
);

  import vrf_geom_pkg::*;

  // Register file port bundles, indexed by the port constants
  addr_t [NrWritePorts-1:0] waddr;
  data_t [NrWritePorts-1:0] wdata;
  logic  [NrWritePorts-1:0] we;
  be_t   [NrWritePorts-1:0] wbe;
  logic  [NrWritePorts-1:0] wvalid;
  addr_t [NrReadPorts-1:0]  raddr;
  logic  [NrReadPorts-1:0]  re;
  data_t [NrReadPorts-1:0]  rdata;
  logic  [NrReadPorts-1:0]  rvalid;

  vec_alu i_vec_alu (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .start_i    (alu_start_i),
    .op_i       (alu_op_i),
    .vd_i       (alu_vd_i),
    .vs1_i      (alu_vs1_i),
    .vs2_i      (alu_vs2_i),
    .busy_o     (alu_busy_o),
    .done_o     (alu_done_o),
    .vs1_addr_o (raddr[ALU_VS1_RD]),
    .vs1_re_o   (re[ALU_VS1_RD]),
    .vs1_data_i (rdata[ALU_VS1_RD]),
    .vs2_addr_o (raddr[ALU_VS2_RD]),
    .vs2_re_o   (re[ALU_VS2_RD]),
    .vs2_data_i (rdata[ALU_VS2_RD]),
    .wr_addr_o  (waddr[ALU_WR]),
    .wr_data_o  (wdata[ALU_WR]),
    .wr_we_o    (we[ALU_WR]),
    .wr_be_o    (wbe[ALU_WR])
  );

  vec_lsu i_vec_lsu (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .load_req_i    (load_req_i),
    .load_addr_i   (load_addr_i),
    .load_data_i   (load_data_i),
    .load_be_i     (load_be_i),
    .load_done_o   (load_done_o),
    .store_req_i   (store_req_i),
    .store_addr_i  (store_addr_i),
    .store_valid_o (store_valid_o),
    .store_data_o  (store_data_o),
    .wr_addr_o     (waddr[LSU_WR]),
    .wr_data_o     (wdata[LSU_WR]),
    .wr_we_o       (we[LSU_WR]),
    .wr_be_o       (wbe[LSU_WR]),
    .wr_valid_i    (wvalid[LSU_WR]),
    .rd_addr_o     (raddr[LSU_RD]),
    .rd_re_o       (re[LSU_RD]),
    .rd_data_i     (rdata[LSU_RD]),
    .rd_valid_i    (rvalid[LSU_RD])
  );

  vec_regfile #(
    .NrRows (NrRows)
  ) i_vec_regfile (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .waddr_i  (waddr),
    .wdata_i  (wdata),
    .we_i     (we),
    .wbe_i    (wbe),
    .wvalid_o (wvalid),
    .raddr_i  (raddr),
    .re_i     (re),
    .rdata_o  (rdata),
    .rvalid_o (rvalid)
  );

endmodule : vrf_sys_top

`default_nettype wire

//--- logic/vec_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module vec_lsu (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Load side
  input  logic                  load_req_i,
  input  vrf_geom_pkg::addr_t   load_addr_i,
  input  vrf_geom_pkg::data_t   load_data_i,
  input  vrf_geom_pkg::be_t     load_be_i,
  output logic                  load_done_o,
  // Store side
  input  logic                  store_req_i,
  input  vrf_geom_pkg::addr_t   store_addr_i,
  output logic                  store_valid_o,
  output vrf_geom_pkg::data_t   store_data_o,
  // Register file write port
  output vrf_geom_pkg::addr_t   wr_addr_o,
  output vrf_geom_pkg::data_t   wr_data_o,
  output logic                  wr_we_o,
  output vrf_geom_pkg::be_t     wr_be_o,
  input  logic                  wr_valid_i,
  // Register file read port
  output vrf_geom_pkg::addr_t   rd_addr_o,
  output logic                  rd_re_o,
  input  vrf_geom_pkg::data_t   rd_data_i,
  input  logic                  rd_valid_i
);

  import vrf_geom_pkg::*;

  logic  load_pend_q;
  logic  load_done_q;
  logic  store_pend_q;
  logic  store_valid_q;
  addr_t load_addr_q;
  data_t load_data_q;
  be_t   load_be_q;
  addr_t store_addr_q;
  data_t store_data_q;

  // Pending flags, each request retries until the register file grants it
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      load_pend_q   <= 1'b0;
      load_done_q   <= 1'b0;
      store_pend_q  <= 1'b0;
      store_valid_q <= 1'b0;
    end else begin
      load_done_q   <= load_pend_q && wr_valid_i;
      store_valid_q <= store_pend_q && rd_valid_i;
      if (!load_pend_q) begin
        load_pend_q <= load_req_i;
      end else if (wr_valid_i) begin
        load_pend_q <= 1'b0;
      end
      if (!store_pend_q) begin
        store_pend_q <= store_req_i;
      end else if (rd_valid_i) begin
        store_pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!load_pend_q && load_req_i) begin
      load_addr_q <= load_addr_i;
      load_data_q <= load_data_i;
      load_be_q   <= load_be_i;
    end
    if (!store_pend_q && store_req_i) begin
      store_addr_q <= store_addr_i;
    end
    // Capture read data in the grant cycle
    if (store_pend_q && rd_valid_i) begin
      store_data_q <= rd_data_i;
    end
  end

  assign wr_addr_o = load_addr_q;
  assign wr_data_o = load_data_q;
  assign wr_be_o   = load_be_q;
  assign wr_we_o   = load_pend_q;

  assign rd_addr_o = store_addr_q;
  assign rd_re_o   = store_pend_q;

  assign load_done_o   = load_done_q;
  assign store_valid_o = store_valid_q;
  assign store_data_o  = store_data_q;

endmodule : vec_lsu

`default_nettype wire

//--- logic/vec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module vec_alu (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Command
  input  logic                  start_i,
  input  vfu_pkg::alu_op_e      op_i,
  input  vrf_geom_pkg::row_t    vd_i,
  input  vrf_geom_pkg::row_t    vs1_i,
  input  vrf_geom_pkg::row_t    vs2_i,
  output logic                  busy_o,
  output logic                  done_o,
  // Operand reads
  output vrf_geom_pkg::addr_t   vs1_addr_o,
  output logic                  vs1_re_o,
  input  vrf_geom_pkg::data_t   vs1_data_i,
  output vrf_geom_pkg::addr_t   vs2_addr_o,
  output logic                  vs2_re_o,
  input  vrf_geom_pkg::data_t   vs2_data_i,
  // Result write
  output vrf_geom_pkg::addr_t   wr_addr_o,
  output vrf_geom_pkg::data_t   wr_data_o,
  output logic                  wr_we_o,
  output vrf_geom_pkg::be_t     wr_be_o
);

  import vrf_geom_pkg::*;
  import vfu_pkg::*;

  alu_state_e          state_q;
  logic [BankBits-1:0] elem_q;
  logic                wr_we_q;
  logic                done_q;
  logic                start;
  logic                last_elem;

  alu_op_e op_q;
  row_t    vd_q;
  row_t    vs1_q;
  row_t    vs2_q;
  addr_t   wr_addr_q;
  data_t   wr_data_q;
  data_t   result;

  assign start     = (state_q == ST_IDLE) && start_i && !busy_o;
  assign last_elem = (elem_q == BankBits'(WordsPerVreg - 1));

  // Element-wise operation, subtract is vs2 - vs1
  always_comb begin
    case (op_q)
      OP_ADD:  result = vs2_data_i + vs1_data_i;
      OP_SUB:  result = vs2_data_i - vs1_data_i;
      OP_AND:  result = vs2_data_i & vs1_data_i;
      OP_XOR:  result = vs2_data_i ^ vs1_data_i;
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      elem_q  <= '0;
      wr_we_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      // A result is written the cycle after its operands were read
      wr_we_q <= (state_q == ST_RUN);
      done_q  <= (state_q == ST_RUN) && last_elem;
      case (state_q)
        ST_IDLE: begin
          if (start) begin
            state_q <= ST_RUN;
            elem_q  <= '0;
          end
        end
        ST_RUN: begin
          elem_q <= elem_q + 1'b1;
          if (last_elem) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Command and result payload
  always_ff @(posedge clk_i) begin
    if (start) begin
      op_q  <= op_i;
      vd_q  <= vd_i;
      vs1_q <= vs1_i;
      vs2_q <= vs2_i;
    end
    if (state_q == ST_RUN) begin
      wr_addr_q <= {vd_q, elem_q};
      wr_data_q <= result;
    end
  end

  assign vs1_addr_o = {vs1_q, elem_q};
  assign vs2_addr_o = {vs2_q, elem_q};
  assign vs1_re_o   = (state_q == ST_RUN);
  assign vs2_re_o   = (state_q == ST_RUN);

  assign wr_addr_o = wr_addr_q;
  assign wr_data_o = wr_data_q;
  assign wr_we_o   = wr_we_q;
  assign wr_be_o   = '1;

  // Busy covers the read phase and the trailing write
  assign busy_o = (state_q == ST_RUN) || wr_we_q;
  assign done_o = done_q;

endmodule : vec_alu

`default_nettype wire

//--- logic/vec_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module vec_regfile #(
  parameter int unsigned NrRows = 8
) (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  // Write ports
  input  vrf_geom_pkg::addr_t [vrf_geom_pkg::NrWritePorts-1:0] waddr_i,
  input  vrf_geom_pkg::data_t [vrf_geom_pkg::NrWritePorts-1:0] wdata_i,
  input  logic                [vrf_geom_pkg::NrWritePorts-1:0] we_i,
  input  vrf_geom_pkg::be_t   [vrf_geom_pkg::NrWritePorts-1:0] wbe_i,
  output logic                [vrf_geom_pkg::NrWritePorts-1:0] wvalid_o,
  // Read ports
  input  vrf_geom_pkg::addr_t [vrf_geom_pkg::NrReadPorts-1:0]  raddr_i,
  input  logic                [vrf_geom_pkg::NrReadPorts-1:0]  re_i,
  output vrf_geom_pkg::data_t [vrf_geom_pkg::NrReadPorts-1:0]  rdata_o,
  output logic                [vrf_geom_pkg::NrReadPorts-1:0]  rvalid_o
);

  import vrf_geom_pkg::*;

  localparam int unsigned RowW = $clog2(NrRows);

  // Per-bank physical port signals
  logic  [NrBanks-1:0][RowW-1:0]      bank_waddr;
  data_t [NrBanks-1:0]                bank_wdata;
  logic  [NrBanks-1:0]                bank_we;
  be_t   [NrBanks-1:0]                bank_wbe;
  logic  [NrBanks-1:0][2:0][RowW-1:0] bank_raddr;
  data_t [NrBanks-1:0][2:0]           bank_rdata;

  logic [NrBanks-1:0][NrWritePorts-1:0] write_request;
  logic [NrBanks-1:0][NrReadPorts-1:0]  read_request;

  ////////////////////////////////////////////////////////////////////////////
  // Bank decode
  ////////////////////////////////////////////////////////////////////////////

  for (genvar bank = 0; bank < NrBanks; bank++) begin : gen_request
    for (genvar port = 0; port < NrWritePorts; port++) begin : gen_wr
      assign write_request[bank][port] =
          we_i[port] && (waddr_i[port][BankBits-1:0] == BankBits'(bank));
    end
    for (genvar port = 0; port < NrReadPorts; port++) begin : gen_rd
      assign read_request[bank][port] =
          re_i[port] && (raddr_i[port][BankBits-1:0] == BankBits'(bank));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write mapping
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    bank_waddr = '0;
    bank_wdata = '0;
    bank_we    = '0;
    bank_wbe   = '0;
    wvalid_o   = '0;

    // One write port per bank, ALU ahead of LSU
    for (int unsigned bank = 0; bank < NrBanks; bank++) begin
      if (write_request[bank][ALU_WR]) begin
        bank_waddr[bank] = waddr_i[ALU_WR][BankBits +: RowW];
        bank_wdata[bank] = wdata_i[ALU_WR];
        bank_we[bank]    = 1'b1;
        bank_wbe[bank]   = wbe_i[ALU_WR];
        wvalid_o[ALU_WR] = 1'b1;
      end else if (write_request[bank][LSU_WR]) begin
        bank_waddr[bank] = waddr_i[LSU_WR][BankBits +: RowW];
        bank_wdata[bank] = wdata_i[LSU_WR];
        bank_we[bank]    = 1'b1;
        bank_wbe[bank]   = wbe_i[LSU_WR];
        wvalid_o[LSU_WR] = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mapping
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Bank read port 2 has no client here and stays at row zero
    bank_raddr = '0;
    rdata_o    = '0;
    rvalid_o   = '0;

    for (int unsigned bank = 0; bank < NrBanks; bank++) begin
      // Bank read port 0 serves vs2 only
      if (read_request[bank][ALU_VS2_RD]) begin
        bank_raddr[bank][0]  = raddr_i[ALU_VS2_RD][BankBits +: RowW];
        rdata_o[ALU_VS2_RD]  = bank_rdata[bank][0];
        rvalid_o[ALU_VS2_RD] = 1'b1;
      end

      // Bank read port 1: vs1 first, then the LSU
      if (read_request[bank][ALU_VS1_RD]) begin
        bank_raddr[bank][1]  = raddr_i[ALU_VS1_RD][BankBits +: RowW];
        rdata_o[ALU_VS1_RD]  = bank_rdata[bank][1];
        rvalid_o[ALU_VS1_RD] = 1'b1;
      end else if (read_request[bank][LSU_RD]) begin
        bank_raddr[bank][1] = raddr_i[LSU_RD][BankBits +: RowW];
        rdata_o[LSU_RD]     = bank_rdata[bank][1];
        rvalid_o[LSU_RD]    = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Banks
  ////////////////////////////////////////////////////////////////////////////

  for (genvar bank = 0; bank < NrBanks; bank++) begin : gen_bank
    vec_bank #(
      .NrRows (NrRows)
    ) i_vec_bank (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .waddr_i (bank_waddr[bank]),
      .wdata_i (bank_wdata[bank]),
      .we_i    (bank_we[bank]),
      .wbe_i   (bank_wbe[bank]),
      .raddr_i (bank_raddr[bank]),
      .rdata_o (bank_rdata[bank])
    );
  end

endmodule : vec_regfile

`default_nettype wire

//--- logic/vec_bank.sv
`timescale 1ns/1ps
`default_nettype none

module vec_bank #(
  parameter int unsigned NrRows = 8
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // Write port
  input  logic [$clog2(NrRows)-1:0]            waddr_i,
  input  vrf_geom_pkg::data_t                  wdata_i,
  input  logic                                 we_i,
  input  vrf_geom_pkg::be_t                    wbe_i,
  // Read ports
  input  logic [2:0][$clog2(NrRows)-1:0]       raddr_i,
  output vrf_geom_pkg::data_t [2:0]            rdata_o
);

  import vrf_geom_pkg::*;

  localparam int unsigned NrBytes = WordWidth / 8;

  data_t mem_q [NrRows];

  // Byte-enabled write, whole bank cleared on reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mem_q <= '{default: '0};
    end else if (we_i) begin
      for (int unsigned b = 0; b < NrBytes; b++) begin
        if (wbe_i[b]) begin
          mem_q[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Asynchronous reads see the old word during a same-cycle write
  for (genvar p = 0; p < 3; p++) begin : gen_read
    assign rdata_o[p] = mem_q[raddr_i[p]];
  end

endmodule : vec_bank

`default_nettype wire

//--- logic/vfu_pkg.sv
`default_nettype none

// Vector functional unit encodings
package vfu_pkg;

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_AND = 2'd2,
    OP_XOR = 2'd3
  } alu_op_e;

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_RUN  = 1'b1
  } alu_state_e;

endpackage : vfu_pkg

`default_nettype wire

//--- logic/vrf_geom_pkg.sv
`default_nettype none

// Geometry of the banked vector register file and its port numbering
package vrf_geom_pkg;

  localparam int unsigned NrBanks      = 4;
  localparam int unsigned WordWidth    = 32;
  localparam int unsigned NrVregs      = 8;
  localparam int unsigned WordsPerVreg = NrBanks;

  localparam int unsigned BankBits = $clog2(NrBanks);
  localparam int unsigned RowBits  = $clog2(NrVregs);

  // Element address: {register number, element index}; element index selects the bank
  typedef logic [RowBits+BankBits-1:0] addr_t;
  typedef logic [RowBits-1:0]          row_t;
  typedef logic [WordWidth-1:0]        data_t;
  typedef logic [WordWidth/8-1:0]      be_t;

  localparam int unsigned NrWritePorts = 2;
  localparam int unsigned NrReadPorts  = 3;

  // Write port indices
  localparam int unsigned ALU_WR = 0;
  localparam int unsigned LSU_WR = 1;

  // Read port indices
  localparam int unsigned ALU_VS2_RD = 0;
  localparam int unsigned ALU_VS1_RD = 1;
  localparam int unsigned LSU_RD     = 2;

endpackage : vrf_geom_pkg

`default_nettype wire
